//--- fpu_params.svh
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// Single-precision field layout
`define FP_WIDTH   32
`define FP_EXP_W   8
`define FP_MAN_W   23
`define FP_WIN_W   48   // Two significands wide
`define FP_EXP_MAX 255

`endif

//--- fpFormatPkg.sv
`default_nettype none

`include "fpu_params.svh"

package fpFormatPkg;

    // Stored exponent field
    typedef logic [`FP_EXP_W-1:0] expT;

    // Stored fraction without the hidden bit
    typedef logic [`FP_MAN_W-1:0] manT;

    typedef logic [`FP_MAN_W:0] sigT;     // Hidden bit plus fraction

    // Alignment and sum window
    typedef logic [`FP_WIN_W-1:0] winT;

    typedef logic [5:0] shiftT;           // 0 to 48

endpackage

`default_nettype wire

//--- fpOpPkg.sv
`default_nettype none

package fpOpPkg;

    // Operation select for the adder
    typedef enum logic {
        opAdd = 1'b0,
        opSub = 1'b1
    } fpOp_e;

endpackage

`default_nettype wire

//--- fpOperandPrep.sv
`default_nettype none

`include "fpu_params.svh"

module fpOperandPrep (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   inValid,
    input  fpOpPkg::fpOp_e         op,
    input  logic [`FP_WIDTH-1:0]   a,
    input  logic [`FP_WIDTH-1:0]   b,
    output logic                   prepValid,
    output logic                   bigSign,
    output fpFormatPkg::expT       bigExp,
    output fpFormatPkg::sigT       bigSig,
    output fpFormatPkg::sigT       smallSig,
    output fpFormatPkg::expT       expDiff,
    output logic                   effSub
);

    import fpFormatPkg::*;
    import fpOpPkg::*;

    logic aSign;
    logic bSign;
    expT  aExp;
    expT  bExp;
    sigT  aSig;
    sigT  bSig;
    logic aBigger;

    assign aSign = a[`FP_WIDTH-1];
    assign bSign = b[`FP_WIDTH-1] ^ (op == opSub);   // Subtract flips b

    assign aExp = a[`FP_WIDTH-2 -: `FP_EXP_W];
    assign bExp = b[`FP_WIDTH-2 -: `FP_EXP_W];

    // Zero exponent field means zero operand, no hidden bit
    assign aSig = {|aExp, a[`FP_MAN_W-1:0]};
    assign bSig = {|bExp, b[`FP_MAN_W-1:0]};

    // Magnitude order, a wins a full tie
    assign aBigger = (aExp > bExp) || ((aExp == bExp) && (aSig >= bSig));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prepValid <= 1'b0;
        end else begin
            prepValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            effSub <= aSign ^ bSign;
            if (aBigger) begin
                bigSign  <= aSign;
                bigExp   <= aExp;
                bigSig   <= aSig;
                smallSig <= bSig;
                expDiff  <= aExp - bExp;
            end else begin
                bigSign  <= bSign;
                bigExp   <= bExp;
                bigSig   <= bSig;
                smallSig <= aSig;
                expDiff  <= bExp - aExp;
            end
        end
    end

endmodule

`default_nettype wire

//--- fpAlignAdd.sv
`default_nettype none

`include "fpu_params.svh"

module fpAlignAdd (
    input  logic              clk,
    input  logic              rstN,
    input  logic              prepValid,
    input  logic              bigSign,
    input  fpFormatPkg::expT  bigExp,
    input  fpFormatPkg::sigT  bigSig,
    input  fpFormatPkg::sigT  smallSig,
    input  fpFormatPkg::expT  expDiff,
    input  logic              effSub,
    output logic              sumValid,
    output logic              sumSign,
    output fpFormatPkg::expT  sumExp,
    output fpFormatPkg::winT  sumWin
);

    import fpFormatPkg::*;

    localparam int PadW = `FP_WIN_W - `FP_MAN_W - 2;   // Zero tail below the significand

    shiftT shiftAmt;
    winT   bigWin;
    winT   smallWin;
    winT   smallShifted;
    winT   sumNext;

    // Spare top bit catches the carry of an add
    assign bigWin   = {1'b0, bigSig, {PadW{1'b0}}};
    assign smallWin = {1'b0, smallSig, {PadW{1'b0}}};

    // Saturate so that far operands shift out completely
    assign shiftAmt = (expDiff >= expT'(`FP_WIN_W)) ? shiftT'(`FP_WIN_W)
                                                    : shiftT'(expDiff);

    assign smallShifted = smallWin >> shiftAmt;

    // Larger magnitude first, so subtract never goes negative
    assign sumNext = effSub ? (bigWin - smallShifted) : (bigWin + smallShifted);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sumValid <= 1'b0;
        end else begin
            sumValid <= prepValid;
        end
    end

    always_ff @(posedge clk) begin
        if (prepValid) begin
            sumSign <= bigSign;
            sumExp  <= bigExp;
            sumWin  <= sumNext;
        end
    end

endmodule

`default_nettype wire

//--- fpNormalize.sv
`default_nettype none

`include "fpu_params.svh"

module fpNormalize (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   sumValid,
    input  logic                   sumSign,
    input  fpFormatPkg::expT       sumExp,
    input  fpFormatPkg::winT       sumWin,
    output logic                   outValid,
    output logic [`FP_WIDTH-1:0]   result,
    output logic                   zeroFlag,
    output logic                   overflowFlag
);

    import fpFormatPkg::*;

    shiftT lz;
    winT   normWin;
    manT   frac;
    logic  signed [`FP_EXP_W+1:0] expWide;   // Room for carry and underflow
    logic  isZero;
    logic  isOver;
    logic  [`FP_WIDTH-1:0] resultNext;

    // Leading zero count, highest set bit wins
    always_comb begin
        lz = shiftT'(`FP_WIN_W);
        for (int i = 0; i < `FP_WIN_W; i++) begin
            if (sumWin[i]) begin
                lz = shiftT'(`FP_WIN_W - 1 - i);
            end
        end
    end

    // Leading one lands on the top bit
    assign normWin = sumWin << lz;
    assign frac    = normWin[`FP_WIN_W-2 -: `FP_MAN_W];

    // Window top bit sits one position above the hidden bit
    assign expWide = $signed({2'b00, sumExp})
                   - $signed({{(`FP_EXP_W - 4){1'b0}}, lz})
                   + 10'sd1;

    assign isZero = (sumWin == '0) || (expWide <= 0);
    assign isOver = !isZero && (expWide >= `FP_EXP_MAX);

    always_comb begin
        if (isZero) begin
            resultNext = '0;                           // Always +0
        end else if (isOver) begin
            resultNext = {sumSign, expT'(`FP_EXP_MAX), manT'(0)};
        end else begin
            resultNext = {sumSign, expWide[`FP_EXP_W-1:0], frac};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid     <= 1'b0;
            result       <= '0;
            zeroFlag     <= 1'b0;
            overflowFlag <= 1'b0;
        end else begin
            outValid <= sumValid;
            if (sumValid) begin
                result       <= resultNext;
                zeroFlag     <= isZero;
                overflowFlag <= isOver;
            end
        end
    end

endmodule

`default_nettype wire

//--- fpAddPipe.sv
`default_nettype none

`include "fpu_params.svh"

module fpAddPipe (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   inValid,
    input  fpOpPkg::fpOp_e         op,
    input  logic [`FP_WIDTH-1:0]   a,
    input  logic [`FP_WIDTH-1:0]   b,
    output logic                   outValid,
    output logic [`FP_WIDTH-1:0]   result,
    output logic                   zeroFlag,
    output logic                   overflowFlag
);

    import fpFormatPkg::*;

    // Stage 1 to stage 2
    logic prepValid;
    logic bigSign;
    expT  bigExp;
    sigT  bigSig;
    sigT  smallSig;
    expT  expDiff;
    logic effSub;

    // Stage 2 to stage 3
    logic sumValid;
    logic sumSign;
    expT  sumExp;
    winT  sumWin;

    fpOperandPrep prep0 (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .op        (op),
        .a         (a),
        .b         (b),
        .prepValid (prepValid),
        .bigSign   (bigSign),
        .bigExp    (bigExp),
        .bigSig    (bigSig),
        .smallSig  (smallSig),
        .expDiff   (expDiff),
        .effSub    (effSub)
    );

    fpAlignAdd align0 (
        .clk       (clk),
        .rstN      (rstN),
        .prepValid (prepValid),
        .bigSign   (bigSign),
        .bigExp    (bigExp),
        .bigSig    (bigSig),
        .smallSig  (smallSig),
        .expDiff   (expDiff),
        .effSub    (effSub),
        .sumValid  (sumValid),
        .sumSign   (sumSign),
        .sumExp    (sumExp),
        .sumWin    (sumWin)
    );

    fpNormalize norm0 (
        .clk          (clk),
        .rstN         (rstN),
        .sumValid     (sumValid),
        .sumSign      (sumSign),
        .sumExp       (sumExp),
        .sumWin       (sumWin),
        .outValid     (outValid),
        .result       (result),
        .zeroFlag     (zeroFlag),
        .overflowFlag (overflowFlag)
    );

endmodule

`default_nettype wire

//--- fpAddPipe_properties.sv
`default_nettype none

`include "fpu_params.svh"

module fpAddPipe_props (
    input logic                 clk,
    input logic                 rstN,
    input logic                 inValid,
    input logic                 outValid,
    input logic [`FP_WIDTH-1:0] result,
    input logic                 zeroFlag,
    input logic                 overflowFlag
);
    timeunit 1ns;
    timeprecision 1ps;

    quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid high while reset is asserted");

    // Three register stages between issue and result
    threeCycleLatency: assert property (@(posedge clk) disable iff (!rstN)
        $past(inValid, 3) |-> outValid)
        else $error("outValid missing three cycles after inValid");

    zeroMeansZero: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && zeroFlag) |-> (result == '0))
        else $error("zeroFlag set with a nonzero result");

    overflowMeansInf: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && overflowFlag) |-> (result[`FP_WIDTH-2 -: `FP_EXP_W] == '1))
        else $error("overflowFlag set without an all-ones exponent");

endmodule

bind fpAddPipe fpAddPipe_props props0 (
    .clk          (clk),
    .rstN         (rstN),
    .inValid      (inValid),
    .outValid     (outValid),
    .result       (result),
    .zeroFlag     (zeroFlag),
    .overflowFlag (overflowFlag)
);

`default_nettype wire

//--- tb_fpAddPipe.sv
`default_nettype none

`include "fpu_params.svh"

module tb_fpAddPipe;
    timeunit 1ns;
    timeprecision 1ps;

    import fpOpPkg::*;
    import fpFormatPkg::*;

    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 3;
    localparam int NumTests    = 5;
    localparam int RandOps     = 200;
    localparam int OpsTotal    = 1 + 16 + 4 + 2 + RandOps;
    localparam int WatchdogCycles = ResetCycles + OpsTotal + 20 * NumTests;
    localparam int ExpHi = `FP_WIDTH - 2;
    localparam int ExpLo = `FP_MAN_W;

    logic                 clk;
    logic                 rstN;
    logic                 inValid;
    fpOp_e                op;
    logic [`FP_WIDTH-1:0] a;
    logic [`FP_WIDTH-1:0] b;
    logic                 outValid;
    logic [`FP_WIDTH-1:0] result;
    logic                 zeroFlag;
    logic                 overflowFlag;

    int          errors = 0;
    int          checks = 0;
    int          seed = 32'h7e6b0c97;
    logic [33:0] expQ[$];    // {zero, overflow, result}
    logic [33:0] expVal;
    logic [31:0] lastResult;
    logic        lastZero;
    logic        lastOver;

    fpAddPipe dut0 (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .op           (op),
        .a            (a),
        .b            (b),
        .outValid     (outValid),
        .result       (result),
        .zeroFlag     (zeroFlag),
        .overflowFlag (overflowFlag)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
        end
    endtask

    // Reference model of the add/subtract rule, truncating
    function automatic logic [33:0] modelAddSub(input logic [31:0] x, input logic [31:0] y,
                                                input fpOp_e opSel);
        logic        sx;
        logic        sy;
        logic        sBig;
        int          ex;
        int          ey;
        int          eBig;
        int          diff;
        int          lz;
        int          expOut;
        logic [23:0] mx;
        logic [23:0] my;
        logic [47:0] wBig;
        logic [47:0] wSmall;
        logic [47:0] wSum;
        logic [47:0] shifted;
        sx = x[31];
        sy = y[31] ^ (opSel == opSub);
        ex = int'(x[ExpHi:ExpLo]);
        ey = int'(y[ExpHi:ExpLo]);
        mx = {ex != 0, x[22:0]};
        my = {ey != 0, y[22:0]};
        if ((ex > ey) || ((ex == ey) && (mx >= my))) begin
            wBig = {1'b0, mx, 23'b0};
            wSmall = {1'b0, my, 23'b0};
            diff = ex - ey;
            eBig = ex;
            sBig = sx;
        end else begin
            wBig = {1'b0, my, 23'b0};
            wSmall = {1'b0, mx, 23'b0};
            diff = ey - ex;
            eBig = ey;
            sBig = sy;
        end
        wSmall = (diff >= 48) ? 48'd0 : (wSmall >> diff);
        wSum = (sx != sy) ? (wBig - wSmall) : (wBig + wSmall);
        lz = 48;
        for (int i = 47; i >= 0; i--) begin
            if (lz == 48 && wSum[i]) lz = 47 - i;
        end
        shifted = wSum << lz;
        expOut = eBig + 1 - lz;
        if (wSum == 48'd0 || expOut <= 0) return {2'b10, 32'h0};
        if (expOut >= 255) return {2'b01, sBig, 8'hff, 23'h0};
        return {2'b00, sBig, expOut[7:0], shifted[46:24]};
    endfunction

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (outValid) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("outValid went high at %0t with no operation outstanding", $time);
            end else begin
                expVal = expQ.pop_front();
                checkValue("result", result, expVal[31:0]);
                checkValue("zeroFlag", {31'b0, zeroFlag}, {31'b0, expVal[33]});
                checkValue("overflowFlag", {31'b0, overflowFlag}, {31'b0, expVal[32]});
            end
            lastResult = result;
            lastZero = zeroFlag;
            lastOver = overflowFlag;
        end
    end

    // Entered and left 2 ns after a rising edge
    task automatic issueOp(input logic [31:0] x, input logic [31:0] y, input fpOp_e opSel);
        inValid = 1'b1;
        a = x;
        b = y;
        op = opSel;
        expQ.push_back(modelAddSub(x, y, opSel));
        @(posedge clk);
        #2;
    endtask

    task automatic waitDrain(input string testName);
        int waited;
        waited = 0;
        inValid = 1'b0;
        while (expQ.size() != 0 && waited < 10) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (expQ.size() != 0) begin
            errors++;
            $display("%s: %0d results never came out", testName, expQ.size());
            expQ.delete();
        end
    endtask

    task automatic runOne(input logic [31:0] x, input logic [31:0] y, input fpOp_e opSel,
                          input string testName);
        issueOp(x, y, opSel);
        waitDrain(testName);
    endtask

    task automatic testResetLatency();
        int lat;
        checkValue("outValid after reset", {31'b0, outValid}, 32'd0);
        @(posedge clk);
        #2;
        checkValue("outValid while idle", {31'b0, outValid}, 32'd0);
        issueOp(32'h3fc00000, 32'h40100000, opAdd);   // 1.5 + 2.25
        inValid = 1'b0;
        lat = 1;   // Issue edge loads the first stage
        while (!outValid && lat < 10) begin
            @(posedge clk);
            #1;
            lat++;
        end
        #1;
        checkValue("outValid latency", lat, 32'd3);
        waitDrain("reset and latency");
        checkValue("1.5 + 2.25", lastResult, 32'h40700000);
    endtask

    task automatic testAlignSign();
        int          dists[4] = '{0, 1, 23, 30};
        logic        sa;
        logic [31:0] x;
        logic [31:0] y;
        fpOp_e       opSel;
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < 4; k++) begin
                sa = k[0];
                if (k[1]) opSel = opSub;
                else opSel = opAdd;
                x = {sa, expT'(130), 23'h2a5b3c};
                y = {~sa, expT'(130 - dists[d]), 23'h51d0e7};   // b larger at distance 0
                issueOp(x, y, opSel);
            end
        end
        waitDrain("alignment and sign");
    endtask

    task automatic testCancelZero();
        runOne(32'h40490fdb, 32'h40490fdb, opSub, "a - a");
        checkValue("a - a result", lastResult, 32'h0);
        checkValue("a - a zeroFlag", {31'b0, lastZero}, 32'd1);
        runOne(32'h40490fdb, 32'hc0490fdb, opAdd, "a + -a");
        checkValue("a + -a zeroFlag", {31'b0, lastZero}, 32'd1);
        runOne(32'h00000000, 32'h3fc00000, opSub, "0 - 1.5");
        checkValue("0 - 1.5", lastResult, 32'hbfc00000);
        runOne(32'h40200000, 32'h00000000, opSub, "2.5 - 0");
        checkValue("2.5 - 0", lastResult, 32'h40200000);
    endtask

    task automatic testRange();
        runOne(32'h7f7fffff, 32'h7f7fffff, opAdd, "overflow");
        checkValue("max + max", lastResult, 32'h7f800000);
        checkValue("max + max overflowFlag", {31'b0, lastOver}, 32'd1);
        runOne(32'h00800001, 32'h00800000, opSub, "underflow");
        checkValue("tiny difference", lastResult, 32'h0);
        checkValue("tiny difference zeroFlag", {31'b0, lastZero}, 32'd1);
    endtask

    task automatic testThroughput();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] r;
        logic [31:0] tmp;
        fpOp_e       opSel;
        int          e;
        int          waited;
        int          run;
        fork
            begin
                for (int n = 0; n < RandOps; n++) begin
                    x = $random(seed);
                    y = $random(seed);
                    r = $random(seed);
                    if (r[1:0] != 2'b00) begin
                        e = int'(x[ExpHi:ExpLo]) - int'(r[7:2]);   // Mostly close exponents
                        y[ExpHi:ExpLo] = (e < 0) ? 8'd0 : e[7:0];
                    end
                    if (x[ExpHi:ExpLo] == 8'hff) x[ExpHi:ExpLo] = 8'hfe;
                    if (y[ExpHi:ExpLo] == 8'hff) y[ExpHi:ExpLo] = 8'hfe;
                    if (r[8]) begin
                        tmp = x;
                        x = y;
                        y = tmp;
                    end
                    if (r[9]) opSel = opSub;
                    else opSel = opAdd;
                    issueOp(x, y, opSel);
                end
                inValid = 1'b0;
            end
            begin
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                end while (!outValid && waited < 20);
                run = 0;
                while (outValid) begin
                    run++;
                    @(negedge clk);
                end
            end
        join
        checkValue("back-to-back output run", run, RandOps);
        waitDrain("throughput");
    endtask

    initial begin
        rstN = 1'b0;
        inValid = 1'b0;
        op = opAdd;
        a = '0;
        b = '0;
        repeat (ResetCycles) @(posedge clk);
        #2;
        rstN = 1'b1;
        testResetLatency();
        testAlignSign();
        testCancelZero();
        testRange();
        testThroughput();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Every operation plus drain time per test
    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, tests did not finish", WatchdogCycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- fpAdd.f
+incdir+.
fpFormatPkg.sv
fpOpPkg.sv
fpOperandPrep.sv
fpAlignAdd.sv
fpNormalize.sv
fpAddPipe.sv
fpAddPipe_properties.sv
tb_fpAddPipe.sv

//--- Makefile
# Verilator build and run for the pipelined FP add/subtract unit

VERILATOR ?= verilator
TOP       ?= tb_fpAddPipe
FILELIST  ?= fpAdd.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= RESULT: PASS

SOURCES := $(wildcard *.sv *.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

# Exit status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
